/* verilog/matmul_pkg.sv */
`default_nettype none

package matmul_pkg;

  // element width and matrix geometry
  localparam int DATA_WIDTH = 8;
  localparam int MAT_SIZE = 4;
  // one memory row per matrix column or row
  localparam int ADDR_WIDTH = 7;
  // host word address, region in the top two bits
  localparam int HOST_ADDR_WIDTH = 9;
  // skew, pass-through across the grid, then the cell pipeline
  localparam int FLUSH_CYCLES = 10;

  typedef logic signed [DATA_WIDTH-1:0] elem_t;

  // element 0 in the low byte, also the bus word
  typedef struct packed {
    elem_t [MAT_SIZE-1:0] e;
  } row_t;

  // whole C matrix, row i at index i
  typedef row_t [MAT_SIZE-1:0] result_t;

  // one memory request
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  we;
    row_t                  wdata;
  } mem_req_t;

  // bit 1 busy, bit 0 done
  typedef struct packed {
    logic busy;
    logic done;
  } status_t;

  typedef enum logic [1:0] {
    REGION_A    = 2'd0,
    REGION_B    = 2'd1,
    REGION_C    = 2'd2,
    REGION_CTRL = 2'd3
  } region_e;

  typedef enum logic {
    GRANT_HOST   = 1'b0,
    GRANT_ENGINE = 1'b1
  } grant_e;

  typedef enum logic [2:0] {IDLE, FEED, FLUSH, WRITE, FINISH} seq_state_e;

endpackage

`default_nettype wire

/* verilog/tile_memory.sv */
`default_nettype none
`timescale 1ns/1ps

module tile_memory #(
  parameter int DEPTH = 128
) (
  input  wire                  clk,
  input  wire matmul_pkg::mem_req_t req,
  output matmul_pkg::row_t     rdata
);

  // one row word per address
  matmul_pkg::row_t mem [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (req.we) begin
      mem[req.addr] <= req.wdata;
    end
  end

  // registered read, old data on a write to the same row
  always_ff @(posedge clk) begin
    rdata <= mem[req.addr];
  end

endmodule

`default_nettype wire

/* verilog/processing_element.sv */
`default_nettype none
`timescale 1ns/1ps

module processing_element (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    acc_clear,
  input  wire matmul_pkg::elem_t in_a,
  input  wire matmul_pkg::elem_t in_b,
  output matmul_pkg::elem_t      out_a,
  output matmul_pkg::elem_t      out_b,
  output matmul_pkg::elem_t      acc
);

  localparam int DW = matmul_pkg::DATA_WIDTH;
  localparam int PW = 2 * DW;
  // clamp limits of an element, product width
  localparam logic signed [PW-1:0] PROD_MAX = (1 <<< (DW - 1)) - 1;
  localparam logic signed [PW-1:0] PROD_MIN = -(1 <<< (DW - 1));

  logic signed [PW-1:0] prod;
  matmul_pkg::elem_t    prod_sat;

  // clamp product into element range
  always_comb begin
    if (prod > PROD_MAX) begin
      prod_sat = PROD_MAX[DW-1:0];
    end else if (prod < PROD_MIN) begin
      prod_sat = PROD_MIN[DW-1:0];
    end else begin
      prod_sat = prod[DW-1:0];
    end
  end

  // input flop doubles as neighbour pass-through
  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
      prod <= '0;
      acc <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
      // full-width signed product
      prod <= out_a * out_b;
      // sum wraps at 8 bits
      if (acc_clear) begin
        acc <= '0;
      end else begin
        acc <= acc + prod_sat;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/systolic_array.sv */
`default_nettype none
`timescale 1ns/1ps

module systolic_array (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   acc_clear,
  input  wire                   feed_valid,
  input  wire matmul_pkg::row_t a_row,
  input  wire matmul_pkg::row_t b_row,
  output matmul_pkg::result_t   result
);

  localparam int N = matmul_pkg::MAT_SIZE;

  matmul_pkg::row_t  a_feed;
  matmul_pkg::row_t  b_feed;
  // a moves right along a row, b moves down a column
  matmul_pkg::elem_t a_h [N][N+1];
  matmul_pkg::elem_t b_v [N+1][N];
  matmul_pkg::elem_t acc_grid [N][N];

  // zeros outside the four feed cycles
  assign a_feed = feed_valid ? a_row : '0;
  assign b_feed = feed_valid ? b_row : '0;

  // lane i of both operands delayed by i cycles
  for (genvar i = 0; i < N; i++) begin : g_skew
    if (i == 0) begin : g_direct
      assign a_h[0][0] = a_feed.e[0];
      assign b_v[0][0] = b_feed.e[0];
    end else begin : g_delay
      matmul_pkg::elem_t a_dly [i];
      matmul_pkg::elem_t b_dly [i];
      always_ff @(posedge clk) begin
        if (reset) begin
          for (int s = 0; s < i; s++) begin
            a_dly[s] <= '0;
            b_dly[s] <= '0;
          end
        end else begin
          a_dly[0] <= a_feed.e[i];
          b_dly[0] <= b_feed.e[i];
          for (int s = 1; s < i; s++) begin
            a_dly[s] <= a_dly[s-1];
            b_dly[s] <= b_dly[s-1];
          end
        end
      end
      assign a_h[i][0] = a_dly[i-1];
      assign b_v[0][i] = b_dly[i-1];
    end
  end

  // cell grid
  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      processing_element u_pe (
        .clk(clk),
        .reset(reset),
        .acc_clear(acc_clear),
        .in_a(a_h[i][j]),
        .in_b(b_v[i][j]),
        .out_a(a_h[i][j+1]),
        .out_b(b_v[i+1][j]),
        .acc(acc_grid[i][j])
      );
    end
  end

  // cell (i,j) holds C[i][j]
  always_comb begin
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        result[i].e[j] = acc_grid[i][j];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/matmul_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module matmul_sequencer (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      start,
  input  wire matmul_pkg::result_t result,
  output matmul_pkg::mem_req_t     ab_req,
  output matmul_pkg::mem_req_t     c_req,
  output logic                     feed_valid,
  output logic                     acc_clear,
  output logic                     run_done
);

  localparam int LAST_ROW = matmul_pkg::MAT_SIZE - 1;
  localparam int ROW_BITS = $clog2(matmul_pkg::MAT_SIZE);

  matmul_pkg::seq_state_e state;
  // feed row, flush count and write row share one counter
  logic [matmul_pkg::ADDR_WIDTH-1:0] cnt;

  // clear on start, before the first product lands
  assign acc_clear = (state == matmul_pkg::IDLE) && start;
  // one-cycle pulse back to the arbiter
  assign run_done = (state == matmul_pkg::FINISH);

  // A and B share the feed address, never written
  always_comb begin
    ab_req.addr = (state == matmul_pkg::FEED) ? cnt : '0;
    ab_req.we = 1'b0;
    ab_req.wdata = '0;
  end

  // result rows straight from the accumulators
  always_comb begin
    c_req.addr = cnt;
    c_req.we = (state == matmul_pkg::WRITE);
    c_req.wdata = result[cnt[ROW_BITS-1:0]];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= matmul_pkg::IDLE;
      cnt <= '0;
      feed_valid <= 1'b0;
    end else begin
      // ram data lags the address by one cycle
      feed_valid <= (state == matmul_pkg::FEED);
      case (state)
        matmul_pkg::IDLE: begin
          if (start) begin
            state <= matmul_pkg::FEED;
            cnt <= '0;
          end
        end
        matmul_pkg::FEED: begin
          if (cnt == LAST_ROW) begin
            state <= matmul_pkg::FLUSH;
            cnt <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        // wait for the last sums to settle
        matmul_pkg::FLUSH: begin
          if (cnt == matmul_pkg::FLUSH_CYCLES - 1) begin
            state <= matmul_pkg::WRITE;
            cnt <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        matmul_pkg::WRITE: begin
          if (cnt == LAST_ROW) begin
            state <= matmul_pkg::FINISH;
            cnt <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= matmul_pkg::IDLE;
          cnt <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/memory_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module memory_arbiter (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       wb_cyc,
  input  wire                       wb_stb,
  input  wire                       wb_we,
  input  wire [matmul_pkg::HOST_ADDR_WIDTH-1:0] wb_adr,
  input  wire matmul_pkg::row_t     wb_dat_w,
  output matmul_pkg::row_t          wb_dat_r,
  output logic                      wb_ack,
  input  wire matmul_pkg::mem_req_t eng_ab_req,
  input  wire matmul_pkg::mem_req_t eng_c_req,
  output matmul_pkg::mem_req_t      a_req,
  output matmul_pkg::mem_req_t      b_req,
  output matmul_pkg::mem_req_t      c_req,
  input  wire matmul_pkg::row_t     a_rdata,
  input  wire matmul_pkg::row_t     b_rdata,
  input  wire matmul_pkg::row_t     c_rdata,
  output logic                      start,
  input  wire                       run_done,
  output matmul_pkg::status_t       status
);

  localparam int PAD_BITS = $bits(matmul_pkg::row_t) - $bits(matmul_pkg::status_t);

  matmul_pkg::region_e  region;
  matmul_pkg::region_e  region_q;
  matmul_pkg::grant_e   grant;
  matmul_pkg::mem_req_t host_mem_req;
  logic host_req;
  logic host_free;
  logic ctrl_go;
  logic mem_go;
  logic start_go;
  logic mem_wait;
  logic done_flag;

  assign host_req = wb_cyc && wb_stb;
  // top two address bits pick the target
  assign region = matmul_pkg::region_e'(wb_adr[matmul_pkg::HOST_ADDR_WIDTH-1 -: 2]);
  // no new request while acking or waiting on ram data
  assign host_free = host_req && !wb_ack && !mem_wait;
  assign ctrl_go = host_free && (region == matmul_pkg::REGION_CTRL);
  // memory cycles stall while the engine owns the bank
  assign mem_go = host_free && (region != matmul_pkg::REGION_CTRL) &&
                  (grant == matmul_pkg::GRANT_HOST);
  // start bit ignored during a run
  assign start_go = ctrl_go && wb_we && wb_dat_w.e[0][0] &&
                    (grant == matmul_pkg::GRANT_HOST);

  assign status = '{busy: (grant == matmul_pkg::GRANT_ENGINE), done: done_flag};

  always_comb begin
    host_mem_req.addr = wb_adr[matmul_pkg::ADDR_WIDTH-1:0];
    host_mem_req.we = 1'b0;
    host_mem_req.wdata = wb_dat_w;
  end

  // bank steering
  always_comb begin
    a_req = host_mem_req;
    a_req.we = mem_go && wb_we && (region == matmul_pkg::REGION_A);
    b_req = host_mem_req;
    b_req.we = mem_go && wb_we && (region == matmul_pkg::REGION_B);
    // C is read-only from the host side
    c_req = host_mem_req;
    if (grant == matmul_pkg::GRANT_ENGINE) begin
      a_req = eng_ab_req;
      b_req = eng_ab_req;
      c_req = eng_c_req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
      mem_wait <= 1'b0;
      start <= 1'b0;
      grant <= matmul_pkg::GRANT_HOST;
      done_flag <= 1'b0;
    end else begin
      // ctrl acks next cycle, memory one cycle later
      wb_ack <= ctrl_go || mem_wait;
      mem_wait <= mem_go;
      start <= start_go;
      if (start_go) begin
        grant <= matmul_pkg::GRANT_ENGINE;
        done_flag <= 1'b0;
      end else if (run_done) begin
        grant <= matmul_pkg::GRANT_HOST;
        done_flag <= 1'b1;
      end
    end
  end

  // read data, held through the ack cycle
  always_ff @(posedge clk) begin
    if (mem_go) begin
      region_q <= region;
    end
    if (ctrl_go) begin
      wb_dat_r <= {{PAD_BITS{1'b0}}, status};
    end else if (mem_wait) begin
      case (region_q)
        matmul_pkg::REGION_A: wb_dat_r <= a_rdata;
        matmul_pkg::REGION_B: wb_dat_r <= b_rdata;
        default:              wb_dat_r <= c_rdata;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/matmul_accel.sv */
`default_nettype none
`timescale 1ns/1ps

module matmul_accel #(
  parameter int DEPTH = 128
) (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   wb_cyc,
  input  wire                   wb_stb,
  input  wire                   wb_we,
  input  wire [matmul_pkg::HOST_ADDR_WIDTH-1:0] wb_adr,
  input  wire matmul_pkg::row_t wb_dat_w,
  output matmul_pkg::row_t      wb_dat_r,
  output logic                  wb_ack
);

  // memory bank ports after the arbiter
  matmul_pkg::mem_req_t a_req;
  matmul_pkg::mem_req_t b_req;
  matmul_pkg::mem_req_t c_req;
  matmul_pkg::row_t     a_rdata;
  matmul_pkg::row_t     b_rdata;
  matmul_pkg::row_t     c_rdata;
  // engine side
  matmul_pkg::mem_req_t eng_ab_req;
  matmul_pkg::mem_req_t eng_c_req;
  matmul_pkg::result_t  result;
  logic start;
  logic run_done;
  logic feed_valid;
  logic acc_clear;

  tile_memory #(.DEPTH(DEPTH)) u_mem_a (.clk(clk), .req(a_req), .rdata(a_rdata));
  tile_memory #(.DEPTH(DEPTH)) u_mem_b (.clk(clk), .req(b_req), .rdata(b_rdata));
  tile_memory #(.DEPTH(DEPTH)) u_mem_c (.clk(clk), .req(c_req), .rdata(c_rdata));

  // host port, status word and bank ownership
  // status only reaches the host through the control region
  memory_arbiter u_arbiter (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .eng_ab_req(eng_ab_req), .eng_c_req(eng_c_req),
    .a_req(a_req), .b_req(b_req), .c_req(c_req),
    .a_rdata(a_rdata), .b_rdata(b_rdata), .c_rdata(c_rdata),
    .start(start), .run_done(run_done), .status()
  );

  matmul_sequencer u_sequencer (
    .clk(clk), .reset(reset), .start(start), .result(result),
    .ab_req(eng_ab_req), .c_req(eng_c_req),
    .feed_valid(feed_valid), .acc_clear(acc_clear), .run_done(run_done)
  );

  // operands straight from the A and B read ports
  systolic_array u_array (
    .clk(clk), .reset(reset), .acc_clear(acc_clear), .feed_valid(feed_valid),
    .a_row(a_rdata), .b_row(b_rdata), .result(result)
  );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module clock_gen #(
  parameter int HALF_PERIOD = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);

  // free-running clock, 8 ns period
  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset held over the first rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

/* bench/matmul_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module matmul_tb;

  localparam int N = matmul_pkg::MAT_SIZE;
  localparam int AW = matmul_pkg::HOST_ADDR_WIDTH;
  localparam int ACK_TIMEOUT = 100;
  localparam int DONE_POLLS = 50;
  localparam int RESET_TIMEOUT = 20;

  logic clk;
  logic reset;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [AW-1:0] wb_adr;
  matmul_pkg::row_t wb_dat_w;
  matmul_pkg::row_t wb_dat_r;
  logic wb_ack;

  int errors;
  int timeouts;
  // operands as [row][col]
  matmul_pkg::elem_t a_mat [N][N];
  matmul_pkg::elem_t b_mat [N][N];

  clock_gen u_clock (.clk(clk), .reset(reset));

  matmul_accel #(.DEPTH(128)) DUT (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  // region in the top two bits and the row below
  function automatic logic [AW-1:0] host_addr(matmul_pkg::region_e region, int row);
    return {region, row[matmul_pkg::ADDR_WIDTH-1:0]};
  endfunction

  // signed value centred on zero over span values
  function automatic matmul_pkg::elem_t rand_elem(int span);
    int v;
    v = int'($urandom_range(span - 1, 0)) - span / 2;
    return matmul_pkg::elem_t'(v);
  endfunction

  // product clamped to the element range
  function automatic int sat_product(int a, int b);
    int p;
    p = a * b;
    if (p > 127) return 127;
    if (p < -128) return -128;
    return p;
  endfunction

  // reference for one C row
  function automatic matmul_pkg::row_t model_row(int i);
    matmul_pkg::row_t r;
    int sum;
    for (int j = 0; j < N; j++) begin
      sum = 0;
      for (int k = 0; k < N; k++) begin
        sum = sum + sat_product(a_mat[i][k], b_mat[k][j]);
      end
      // sum wraps to the low byte
      r.e[j] = sum[7:0];
    end
    return r;
  endfunction

  // memory A word t is column t
  function automatic matmul_pkg::row_t a_word(int t);
    matmul_pkg::row_t r;
    for (int i = 0; i < N; i++) r.e[i] = a_mat[i][t];
    return r;
  endfunction

  // memory B word t is row t
  function automatic matmul_pkg::row_t b_word(int t);
    matmul_pkg::row_t r;
    for (int j = 0; j < N; j++) r.e[j] = b_mat[t][j];
    return r;
  endfunction

  task automatic check_row(string name, matmul_pkg::row_t got, matmul_pkg::row_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_status(string name, matmul_pkg::status_t got,
                              matmul_pkg::status_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // drive on the falling edge and sample ack on a later one
  task automatic bus_cycle(logic we, logic [AW-1:0] adr, matmul_pkg::row_t wdata,
                           output matmul_pkg::row_t rdata, output int waited);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    waited = 0;
    while (!wb_ack && waited < ACK_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    rdata = wb_dat_r;
    if (!wb_ack) begin
      timeouts++;
      $display("no ack for access to address %h within %0d cycles", adr, ACK_TIMEOUT);
    end
    // ack is a single pulse so the strobe drops here
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_write(logic [AW-1:0] adr, matmul_pkg::row_t data);
    matmul_pkg::row_t unused;
    int waited;
    bus_cycle(1'b1, adr, data, unused, waited);
  endtask

  task automatic wb_read(logic [AW-1:0] adr, output matmul_pkg::row_t data,
                         output int waited);
    bus_cycle(1'b0, adr, '0, data, waited);
  endtask

  task automatic read_status(output matmul_pkg::status_t st);
    matmul_pkg::row_t word;
    int waited;
    wb_read(host_addr(matmul_pkg::REGION_CTRL, 0), word, waited);
    st = matmul_pkg::status_t'(word[1:0]);
  endtask

  task automatic wait_done();
    matmul_pkg::status_t st;
    int polls;
    polls = 0;
    st = '0;
    while (!st.done && polls < DONE_POLLS) begin
      read_status(st);
      polls++;
    end
    if (!st.done) begin
      timeouts++;
      $display("run never reported done within %0d status polls", DONE_POLLS);
    end
  endtask

  task automatic load_operands();
    for (int t = 0; t < N; t++) begin
      wb_write(host_addr(matmul_pkg::REGION_A, t), a_word(t));
      wb_write(host_addr(matmul_pkg::REGION_B, t), b_word(t));
    end
  endtask

  task automatic start_run();
    wb_write(host_addr(matmul_pkg::REGION_CTRL, 0), matmul_pkg::row_t'(32'h1));
  endtask

  task automatic check_results();
    matmul_pkg::row_t got;
    int waited;
    for (int i = 0; i < N; i++) begin
      wb_read(host_addr(matmul_pkg::REGION_C, i), got, waited);
      check_row($sformatf("c row %0d", i), got, model_row(i));
    end
  endtask

  task automatic randomize_operands(int span);
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        a_mat[i][j] = rand_elem(span);
        b_mat[i][j] = rand_elem(span);
      end
    end
  endtask

  task automatic test_reset_state();
    matmul_pkg::status_t st;
    // cyc alone and then an idle bus never get an ack
    @(negedge clk);
    wb_cyc = 1'b1;
    for (int n = 0; n < 6; n++) begin
      @(negedge clk);
      if (n == 3) wb_cyc = 1'b0;
      check_bit("wb_ack", wb_ack, 1'b0);
    end
    read_status(st);
    check_status("status after reset", st, '{busy: 1'b0, done: 1'b0});
  endtask

  task automatic test_ab_readback();
    matmul_pkg::row_t wa;
    matmul_pkg::row_t wb;
    matmul_pkg::row_t got;
    int row;
    int waited;
    for (int n = 0; n < 8; n++) begin
      row = (n < N) ? n : int'($urandom_range(127, N));
      for (int e = 0; e < N; e++) begin
        wa.e[e] = rand_elem(256);
        wb.e[e] = rand_elem(256);
      end
      wb_write(host_addr(matmul_pkg::REGION_A, row), wa);
      wb_write(host_addr(matmul_pkg::REGION_B, row), wb);
      wb_read(host_addr(matmul_pkg::REGION_A, row), got, waited);
      check_row($sformatf("a word %0d", row), got, wa);
      wb_read(host_addr(matmul_pkg::REGION_B, row), got, waited);
      check_row($sformatf("b word %0d", row), got, wb);
    end
  endtask

  task automatic test_identity();
    // identity A with small B values
    randomize_operands(16);
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) a_mat[i][j] = (i == j) ? 8'sd1 : 8'sd0;
    end
    load_operands();
    start_run();
    wait_done();
    check_results();
  endtask

  task automatic test_c_write_ignored();
    matmul_pkg::row_t got;
    int waited;
    // C still holds the identity result
    wb_write(host_addr(matmul_pkg::REGION_C, 1), matmul_pkg::row_t'($urandom()));
    wb_read(host_addr(matmul_pkg::REGION_C, 1), got, waited);
    check_row("c row 1 after host write", got, model_row(1));
  endtask

  task automatic test_random_full();
    randomize_operands(256);
    // force saturated products in one cell
    a_mat[0][0] = -8'sd128;
    b_mat[0][0] = -8'sd128;
    // row 1 times column 1 clamps every product and wraps the sum
    for (int k = 0; k < N; k++) begin
      a_mat[1][k] = 8'sd127;
      b_mat[k][1] = 8'sd127;
    end
    load_operands();
    start_run();
    wait_done();
    check_results();
  endtask

  task automatic test_stall_during_run();
    matmul_pkg::row_t got;
    matmul_pkg::status_t st;
    int waited;
    randomize_operands(256);
    load_operands();
    start_run();
    // host memory read held off until the engine lets go
    wb_read(host_addr(matmul_pkg::REGION_A, 2), got, waited);
    if (waited <= matmul_pkg::FLUSH_CYCLES) begin
      errors++;
      $display("read of A was acked after %0d cycles while the run was busy", waited);
    end
    check_row("a word 2 after stall", got, a_word(2));
    read_status(st);
    check_status("status after stalled read", st, '{busy: 1'b0, done: 1'b1});
    check_results();
  endtask

  task automatic test_second_run();
    matmul_pkg::status_t st;
    randomize_operands(256);
    load_operands();
    start_run();
    // done cleared by the new start
    read_status(st);
    check_status("status after restart", st, '{busy: 1'b1, done: 1'b0});
    check_bit("busy after restart", st.busy, 1'b1);
    wait_done();
    check_results();
  endtask

  initial begin
    int waited;
    errors = 0;
    timeouts = 0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    // seed the generator once
    void'($urandom(27342));
    waited = 0;
    while (reset !== 1'b0 && waited < RESET_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (reset !== 1'b0) begin
      timeouts++;
      $display("reset was never released");
    end
    test_reset_state();
    test_ab_readback();
    test_identity();
    test_c_write_ignored();
    test_random_full();
    test_stall_during_run();
    test_second_run();
    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
verilog/matmul_pkg.sv
verilog/tile_memory.sv
verilog/processing_element.sv
verilog/systolic_array.sv
verilog/matmul_sequencer.sv
verilog/memory_arbiter.sv
verilog/matmul_accel.sv
bench/clock_gen.sv
bench/matmul_tb.sv

/* Bender.yml */
package:
  name: matmul_accel

sources:
  - verilog/matmul_pkg.sv
  - verilog/tile_memory.sv
  - verilog/processing_element.sv
  - verilog/systolic_array.sv
  - verilog/matmul_sequencer.sv
  - verilog/memory_arbiter.sv
  - verilog/matmul_accel.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/matmul_tb.sv
